// ==== hdl/axil_soc_pkg.sv ====
package axil_soc_pkg;

	// address map
	localparam int NUM_RAM_BANKS = 4;
	localparam logic [31:0] RAM_BASE = 32'h8000_0000;
	localparam int RAM_BANK_BYTES = 256;
	localparam int RAM_WORDS = RAM_BANK_BYTES / 4;
	localparam logic [31:0] RAM_SPAN = 32'(NUM_RAM_BANKS * RAM_BANK_BYTES);
	localparam logic [31:0] RTC_BASE = 32'hA000_0048;
	localparam int RTC_BYTES = 8;

	// derived field widths
	localparam int BANK_SHIFT = $clog2(RAM_BANK_BYTES);
	localparam int BANK_IDX_W = $clog2(NUM_RAM_BANKS);
	localparam int WORD_IDX_W = $clog2(RAM_WORDS);

	typedef enum logic [1:0] {
		OKAY = 2'd0,
		SLVERR = 2'd2,
		DECERR = 2'd3
	} resp_e;

	typedef enum logic [2:0] {
		IDLE,
		BUSY_RAM,
		BUSY_RTC,
		ERR_ACCEPT,
		ERR_RESP
	} xbar_state_e;

	typedef enum logic [1:0] {
		T_RAM,
		T_RTC,
		T_NONE
	} target_e;

	typedef struct packed {
		logic [31:0] addr;
	} ar_req_t;

	typedef struct packed {
		logic [31:0] data;
		resp_e resp;
	} r_rsp_t;

	typedef struct packed {
		logic [31:0] addr;
	} aw_req_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0] strb;
	} w_req_t;

	typedef struct packed {
		resp_e resp;
	} b_rsp_t;

endpackage

// ==== hdl/axil_ram.sv ====
`timescale 1ns/1ps

module axil_ram import axil_soc_pkg::*; (
	input logic clk,
	input logic rst,
	input ar_req_t ar,
	input logic arvalid,
	output logic arready,
	output r_rsp_t r,
	output logic rvalid,
	input logic rready,
	input aw_req_t aw,
	input logic awvalid,
	output logic awready,
	input w_req_t w,
	input logic wvalid,
	output logic wready,
	output b_rsp_t b,
	output logic bvalid,
	input logic bready
);

	logic [31:0] mem [RAM_WORDS];
	logic [31:0] rdata_q;
	logic [WORD_IDX_W-1:0] rd_idx, wr_idx;
	logic rsp_pending;
	logic rd_fire, wr_fire;

	// addresses arrive as word indices
	assign rd_idx = ar.addr[WORD_IDX_W-1:0];
	assign wr_idx = aw.addr[WORD_IDX_W-1:0];

	assign rsp_pending = rvalid || bvalid;

	// one request at a time, read first
	assign arready = arvalid && !rsp_pending;
	assign awready = awvalid && wvalid && !arvalid && !rsp_pending;
	assign wready = awready;

	assign rd_fire = arvalid && arready;
	assign wr_fire = awvalid && awready;

	assign r = '{data: rdata_q, resp: OKAY};
	assign b = '{resp: OKAY};

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;

			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire)
			rdata_q <= mem[rd_idx];
	end

	// byte merge under strobe
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			for (int k = 0; k < 4; k++) begin
				if (w.strb[k])
					mem[wr_idx][8*k +: 8] <= w.data[8*k +: 8];
			end
		end
	end

endmodule

// ==== hdl/axil_rtc.sv ====
`timescale 1ns/1ps

module axil_rtc import axil_soc_pkg::*; (
	input logic clk,
	input logic rst,
	input ar_req_t ar,
	input logic arvalid,
	output logic arready,
	output r_rsp_t r,
	output logic rvalid,
	input logic rready
);

	logic [63:0] count;
	logic [31:0] hi_snap;
	logic [31:0] rdata_q;
	logic rd_fire;

	assign arready = arvalid && !rvalid;
	assign rd_fire = arvalid && arready;
	assign r = '{data: rdata_q, resp: OKAY};

	// free-running cycle count
	always_ff @(posedge clk) begin
		if (rst)
			count <= 64'h0;
		else
			count <= count + 64'h1;
	end

	always_ff @(posedge clk) begin
		if (rst)
			rvalid <= 1'b0;
		else if (rd_fire)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	// low word read freezes the high half for the following read
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			if (!ar.addr[0]) begin
				rdata_q <= count[31:0];
				hi_snap <= count[63:32];
			end else begin
				rdata_q <= hi_snap;
			end
		end
	end

endmodule

// ==== hdl/axil_xbar.sv ====
`timescale 1ns/1ps

module axil_xbar import axil_soc_pkg::*; (
	input logic clk,
	input logic rst,
	// manager side
	input ar_req_t ar,
	input logic arvalid,
	output logic arready,
	output r_rsp_t r,
	output logic rvalid,
	input logic rready,
	input aw_req_t aw,
	input logic awvalid,
	output logic awready,
	input w_req_t w,
	input logic wvalid,
	output logic wready,
	output b_rsp_t b,
	output logic bvalid,
	input logic bready,
	// ram banks
	output ar_req_t ram_ar [NUM_RAM_BANKS],
	output logic [NUM_RAM_BANKS-1:0] ram_arvalid,
	input logic [NUM_RAM_BANKS-1:0] ram_arready,
	input r_rsp_t ram_r [NUM_RAM_BANKS],
	input logic [NUM_RAM_BANKS-1:0] ram_rvalid,
	output logic [NUM_RAM_BANKS-1:0] ram_rready,
	output aw_req_t ram_aw [NUM_RAM_BANKS],
	output logic [NUM_RAM_BANKS-1:0] ram_awvalid,
	input logic [NUM_RAM_BANKS-1:0] ram_awready,
	output w_req_t ram_w [NUM_RAM_BANKS],
	output logic [NUM_RAM_BANKS-1:0] ram_wvalid,
	input logic [NUM_RAM_BANKS-1:0] ram_wready,
	input b_rsp_t ram_b [NUM_RAM_BANKS],
	input logic [NUM_RAM_BANKS-1:0] ram_bvalid,
	output logic [NUM_RAM_BANKS-1:0] ram_bready,
	// counter, read only
	output ar_req_t rtc_ar,
	output logic rtc_arvalid,
	input logic rtc_arready,
	input r_rsp_t rtc_r,
	input logic rtc_rvalid,
	output logic rtc_rready
);

	xbar_state_e state, state_d;
	logic wr_q;
	logic [BANK_IDX_W-1:0] bank_q;
	resp_e err_q;
	logic req_sent_q;

	logic req_rd, req_wr;
	logic [31:0] sel_addr, sel_off;
	target_e sel_tgt;
	logic [BANK_IDX_W-1:0] sel_bank;
	logic [31:0] rd_off, wr_off, rtc_off;
	logic req_hs, rsp_hs;

	function automatic target_e decode(input logic [31:0] addr);
		if (addr >= RAM_BASE && addr < RAM_BASE + RAM_SPAN)
			return T_RAM;
		if (addr >= RTC_BASE && addr < RTC_BASE + 32'(RTC_BYTES))
			return T_RTC;
		return T_NONE;
	endfunction

	// reads win over writes
	assign req_rd = arvalid;
	assign req_wr = !arvalid && awvalid && wvalid;
	assign sel_addr = arvalid ? ar.addr : aw.addr;
	assign sel_tgt = decode(sel_addr);
	assign sel_off = sel_addr - RAM_BASE;
	assign sel_bank = sel_off[BANK_SHIFT +: BANK_IDX_W];

	// offsets relative to each slave base
	assign rd_off = ar.addr - RAM_BASE;
	assign wr_off = aw.addr - RAM_BASE;
	assign rtc_off = ar.addr - RTC_BASE;

	assign req_hs = wr_q ? (awvalid && awready) : (arvalid && arready);
	assign rsp_hs = (rvalid && rready) || (bvalid && bready);

	always_comb begin
		state_d = state;
		case (state)
			IDLE: begin
				if (req_rd || req_wr) begin
					if (sel_tgt == T_RAM)
						state_d = BUSY_RAM;
					else if (sel_tgt == T_RTC && req_rd)
						state_d = BUSY_RTC;
					else
						state_d = ERR_ACCEPT;
				end
			end
			BUSY_RAM, BUSY_RTC, ERR_RESP: begin
				if (rsp_hs)
					state_d = IDLE;
			end
			ERR_ACCEPT: state_d = ERR_RESP;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			wr_q <= 1'b0;
			bank_q <= '0;
			err_q <= OKAY;
			req_sent_q <= 1'b0;
		end else begin
			state <= state_d;
			if (state == IDLE) begin
				wr_q <= req_wr;
				bank_q <= sel_bank;
				// writes to the counter are refused, everything unmapped is a decode error
				err_q <= (sel_tgt == T_RTC) ? SLVERR : DECERR;
				req_sent_q <= 1'b0;
			end else if (req_hs) begin
				req_sent_q <= 1'b1;
			end
		end
	end

	// routing of the selected slave to the manager port
	always_comb begin
		arready = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		rvalid = 1'b0;
		bvalid = 1'b0;
		r = '{data: 32'h0, resp: OKAY};
		b = '{resp: OKAY};
		for (int i = 0; i < NUM_RAM_BANKS; i++) begin
			ram_ar[i] = '{addr: 32'(rd_off[BANK_SHIFT-1:2])};
			ram_aw[i] = '{addr: 32'(wr_off[BANK_SHIFT-1:2])};
			ram_w[i] = w;
		end
		ram_arvalid = '0;
		ram_awvalid = '0;
		ram_wvalid = '0;
		ram_rready = '0;
		ram_bready = '0;
		// counter word index, 0 low and 1 high
		rtc_ar = '{addr: {31'h0, rtc_off[2]}};
		rtc_arvalid = 1'b0;
		rtc_rready = 1'b0;
		case (state)
			BUSY_RAM: begin
				if (wr_q) begin
					ram_awvalid[bank_q] = awvalid && !req_sent_q;
					ram_wvalid[bank_q] = wvalid && !req_sent_q;
					awready = ram_awready[bank_q];
					wready = ram_wready[bank_q];
					b = ram_b[bank_q];
					bvalid = ram_bvalid[bank_q];
					ram_bready[bank_q] = bready;
				end else begin
					ram_arvalid[bank_q] = arvalid && !req_sent_q;
					arready = ram_arready[bank_q];
					r = ram_r[bank_q];
					rvalid = ram_rvalid[bank_q];
					ram_rready[bank_q] = rready;
				end
			end
			BUSY_RTC: begin
				rtc_arvalid = arvalid && !req_sent_q;
				arready = rtc_arready;
				r = rtc_r;
				rvalid = rtc_rvalid;
				rtc_rready = rready;
			end
			ERR_ACCEPT: begin
				// swallow the request for one cycle
				if (wr_q) begin
					awready = 1'b1;
					wready = 1'b1;
				end else begin
					arready = 1'b1;
				end
			end
			ERR_RESP: begin
				if (wr_q) begin
					bvalid = 1'b1;
					b = '{resp: err_q};
				end else begin
					rvalid = 1'b1;
					r = '{data: 32'h0, resp: DECERR};
				end
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== hdl/axil_soc.sv ====
`timescale 1ns/1ps

module axil_soc import axil_soc_pkg::*; (
	input logic clk,
	input logic rst,
	input ar_req_t ar,
	input logic arvalid,
	output logic arready,
	output r_rsp_t r,
	output logic rvalid,
	input logic rready,
	input aw_req_t aw,
	input logic awvalid,
	output logic awready,
	input w_req_t w,
	input logic wvalid,
	output logic wready,
	output b_rsp_t b,
	output logic bvalid,
	input logic bready
);

	// per-bank channels
	ar_req_t ram_ar [NUM_RAM_BANKS];
	r_rsp_t ram_r [NUM_RAM_BANKS];
	aw_req_t ram_aw [NUM_RAM_BANKS];
	w_req_t ram_w [NUM_RAM_BANKS];
	b_rsp_t ram_b [NUM_RAM_BANKS];
	logic [NUM_RAM_BANKS-1:0] ram_arvalid, ram_arready;
	logic [NUM_RAM_BANKS-1:0] ram_rvalid, ram_rready;
	logic [NUM_RAM_BANKS-1:0] ram_awvalid, ram_awready;
	logic [NUM_RAM_BANKS-1:0] ram_wvalid, ram_wready;
	logic [NUM_RAM_BANKS-1:0] ram_bvalid, ram_bready;

	// counter channels
	ar_req_t rtc_ar;
	r_rsp_t rtc_r;
	logic rtc_arvalid, rtc_arready;
	logic rtc_rvalid, rtc_rready;

	// every crossbar port has a same-named net here
	axil_xbar u_axil_xbar (.*);

	for (genvar i = 0; i < NUM_RAM_BANKS; i++) begin : g_ram
		axil_ram u_axil_ram (
			.clk(clk),
			.rst(rst),
			.ar(ram_ar[i]), .arvalid(ram_arvalid[i]), .arready(ram_arready[i]),
			.r(ram_r[i]), .rvalid(ram_rvalid[i]), .rready(ram_rready[i]),
			.aw(ram_aw[i]), .awvalid(ram_awvalid[i]), .awready(ram_awready[i]),
			.w(ram_w[i]), .wvalid(ram_wvalid[i]), .wready(ram_wready[i]),
			.b(ram_b[i]), .bvalid(ram_bvalid[i]), .bready(ram_bready[i])
		);
	end

	axil_rtc u_axil_rtc (
		.clk(clk),
		.rst(rst),
		.ar(rtc_ar), .arvalid(rtc_arvalid), .arready(rtc_arready),
		.r(rtc_r), .rvalid(rtc_rvalid), .rready(rtc_rready)
	);

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst
);

	localparam int RESET_CYCLES = 16;

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== testbench/axil_soc_properties.sv ====
`timescale 1ns/1ps

module axil_soc_properties import axil_soc_pkg::*; (
	input logic clk,
	input logic rst,
	input r_rsp_t r,
	input logic rvalid,
	input logic rready,
	input b_rsp_t b,
	input logic bvalid,
	input logic bready,
	input logic arready,
	input logic awready,
	input logic wready,
	input logic [NUM_RAM_BANKS-1:0] ram_arvalid,
	input logic [NUM_RAM_BANKS-1:0] ram_awvalid,
	input logic [NUM_RAM_BANKS-1:0] ram_wvalid,
	input logic rtc_arvalid
);

	// manager side stays quiet once reset has been seen for a full cycle
	reset_quiet: assert property (@(posedge clk)
		rst && $past(rst) |-> !rvalid && !bvalid && !arready && !awready && !wready)
		else $error("manager handshake outputs active during reset");

	r_hold: assert property (@(posedge clk) disable iff (rst)
		$past(rvalid && !rready) |-> rvalid && $stable(r))
		else $error("read response dropped or changed before rready");

	b_hold: assert property (@(posedge clk) disable iff (rst)
		$past(bvalid && !bready) |-> bvalid && $stable(b))
		else $error("write response dropped or changed before bready");

	// one transaction at a time
	rsp_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(rvalid && bvalid))
		else $error("read and write responses posted together");

	down_ar_aw_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({ram_arvalid, ram_awvalid, rtc_arvalid}))
		else $error("more than one downstream request valid");

	down_ar_w_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({ram_arvalid, ram_wvalid, rtc_arvalid}))
		else $error("more than one downstream write data valid");

endmodule

// ==== testbench/axil_soc_tb.sv ====
`timescale 1ns/1ps

module axil_soc_tb import axil_soc_pkg::*; ();

	localparam int SEED = 56145;
	// about 250 transactions of up to 12 cycles, doubled
	localparam int TIMEOUT_CYCLES = 6000;
	localparam int NUM_RANDOM_WRITES = 48;

	logic clk, rst;
	ar_req_t ar;
	logic arvalid, arready;
	r_rsp_t r;
	logic rvalid, rready;
	aw_req_t aw;
	logic awvalid, awready;
	w_req_t w;
	logic wvalid, wready;
	b_rsp_t b;
	logic bvalid, bready;

	// shadow copy of the ram banks
	logic [31:0] model [NUM_RAM_BANKS][RAM_WORDS];
	bit written [NUM_RAM_BANKS][RAM_WORDS];
	int cycle_count = 0;
	int r_done_cycle, b_done_cycle;

	tb_clock u_tb_clock (.clk(clk), .rst(rst));

	axil_soc u_axil_soc (.*);

	bind axil_xbar axil_soc_properties u_axil_soc_properties (
		.clk(clk), .rst(rst),
		.r(r), .rvalid(rvalid), .rready(rready),
		.b(b), .bvalid(bvalid), .bready(bready),
		.arready(arready), .awready(awready), .wready(wready),
		.ram_arvalid(ram_arvalid), .ram_awvalid(ram_awvalid),
		.ram_wvalid(ram_wvalid), .rtc_arvalid(rtc_arvalid)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp)
			else fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
			fail_run("timeout, the test did not finish within the cycle limit");
	end

	function automatic logic [31:0] ram_addr(input int bank, input int word);
		return RAM_BASE + 32'(bank * RAM_BANK_BYTES) + 32'(word * 4);
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
			input logic [31:0] data, input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int k = 0; k < 4; k++)
			if (strb[k])
				res[8*k +: 8] = data[8*k +: 8];
		return res;
	endfunction

	// ready is sampled at the falling edge, the transfer is the next rising edge
	task automatic read_word(input logic [31:0] addr, output r_rsp_t rsp);
		int unsigned delay;
		delay = $urandom_range(3, 0);
		@(posedge clk);
		ar <= '{addr: addr};
		arvalid <= 1'b1;
		do @(negedge clk); while (!arready);
		@(posedge clk);
		arvalid <= 1'b0;
		repeat (delay) @(posedge clk);
		rready <= 1'b1;
		do @(negedge clk); while (!rvalid);
		rsp = r;
		r_done_cycle = cycle_count;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output b_rsp_t rsp);
		int unsigned delay;
		delay = $urandom_range(3, 0);
		@(posedge clk);
		aw <= '{addr: addr};
		w <= '{data: data, strb: strb};
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do @(negedge clk); while (!(awready && wready));
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		repeat (delay) @(posedge clk);
		bready <= 1'b1;
		do @(negedge clk); while (!bvalid);
		rsp = b;
		b_done_cycle = cycle_count;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic write_ram(input int bank, input int word, input logic [31:0] data,
			input logic [3:0] strb);
		b_rsp_t rsp;
		write_word(ram_addr(bank, word), data, strb, rsp);
		check_value("b.resp", 32'(rsp.resp), 32'(OKAY));
		model[bank][word] = merge_bytes(model[bank][word], data, strb);
		written[bank][word] = 1'b1;
	endtask

	task automatic check_ram(input int bank, input int word);
		r_rsp_t rsp;
		read_word(ram_addr(bank, word), rsp);
		check_value("r.data", rsp.data, model[bank][word]);
		check_value("r.resp", 32'(rsp.resp), 32'(OKAY));
	endtask

	task automatic check_all_ram();
		for (int i = 0; i < NUM_RAM_BANKS; i++)
			for (int j = 0; j < RAM_WORDS; j++)
				if (written[i][j])
					check_ram(i, j);
	endtask

	// low word first, the high word comes from the snapshot
	task automatic read_counter(output logic [63:0] value);
		r_rsp_t lo, hi;
		read_word(RTC_BASE, lo);
		check_value("r.resp", 32'(lo.resp), 32'(OKAY));
		read_word(RTC_BASE + 32'd4, hi);
		check_value("r.resp", 32'(hi.resp), 32'(OKAY));
		// the run ends long before the count reaches the high word
		check_value("r.data", hi.data, 32'h0);
		value = {hi.data, lo.data};
		assert (value != 64'h0) else fail_run("counter read returned zero");
	endtask

	task automatic check_unmapped(input logic [31:0] addr);
		r_rsp_t rrsp;
		b_rsp_t brsp;
		read_word(addr, rrsp);
		check_value("r.data", rrsp.data, 32'h0);
		check_value("r.resp", 32'(rrsp.resp), 32'(DECERR));
		write_word(addr, $urandom(), 4'hF, brsp);
		check_value("b.resp", 32'(brsp.resp), 32'(DECERR));
	endtask

	initial begin
		logic [63:0] count_a, count_b;
		logic [31:0] old_word;
		logic [3:0] strb;
		r_rsp_t rrsp;
		b_rsp_t brsp;
		int bank, word;

		void'($urandom(SEED));
		ar <= '{addr: 32'h0};
		arvalid <= 1'b0;
		rready <= 1'b0;
		aw <= '{addr: 32'h0};
		w <= '{data: 32'h0, strb: 4'h0};
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		bready <= 1'b0;
		wait (!rst);

		// first write to a word uses all strobes so no byte stays unknown
		for (int n = 0; n < NUM_RANDOM_WRITES; n++) begin
			bank = int'($urandom_range(NUM_RAM_BANKS - 1, 0));
			word = int'($urandom_range(RAM_WORDS - 1, 0));
			strb = written[bank][word] ? 4'($urandom()) : 4'hF;
			write_ram(bank, word, $urandom(), strb);
		end
		check_all_ram();

		// same offset, different value per bank
		for (int i = 0; i < NUM_RAM_BANKS; i++)
			write_ram(i, 5, 32'h1111_1111 * 32'(i + 1), 4'hF);
		for (int i = 0; i < NUM_RAM_BANKS; i++)
			check_ram(i, 5);

		read_counter(count_a);
		repeat (10) @(posedge clk);
		read_counter(count_b);
		assert (count_b > count_a) else fail_run("counter did not advance between reads");

		// counter is read only
		write_word(RTC_BASE, 32'hDEAD_BEEF, 4'hF, brsp);
		check_value("b.resp", 32'(brsp.resp), 32'(SLVERR));
		write_word(RTC_BASE + 32'd4, 32'h0000_0001, 4'hF, brsp);
		check_value("b.resp", 32'(brsp.resp), 32'(SLVERR));
		read_counter(count_a);
		assert (count_a > count_b) else fail_run("counter did not advance after refused write");

		// words the unmapped addresses below alias to in their low ten bits
		write_ram(0, 0, 32'h0BAD_0000, 4'hF);
		write_ram(0, 17, 32'h0BAD_0011, 4'hF);
		write_ram(0, 20, 32'h0BAD_0014, 4'hF);
		write_ram(3, 63, 32'h0BAD_003F, 4'hF);

		check_unmapped(32'h0000_0000);
		check_unmapped(RAM_BASE - 32'd4);
		check_unmapped(RAM_BASE + RAM_SPAN);
		check_unmapped(RTC_BASE - 32'd4);
		check_unmapped(RTC_BASE + 32'(RTC_BYTES));
		check_unmapped(32'hFFFF_FFFC);
		check_all_ram();

		// read and write to one word raised together, read goes first
		old_word = model[2][5];
		fork
			read_word(ram_addr(2, 5), rrsp);
			write_word(ram_addr(2, 5), 32'hC0DE_0042, 4'hF, brsp);
		join
		assert (r_done_cycle < b_done_cycle)
			else fail_run("write response arrived before the read response");
		check_value("r.data", rrsp.data, old_word);
		check_value("r.resp", 32'(rrsp.resp), 32'(OKAY));
		check_value("b.resp", 32'(brsp.resp), 32'(OKAY));
		model[2][5] = 32'hC0DE_0042;
		check_ram(2, 5);

		$display("All checks passed");
		$finish;
	end

endmodule

// ==== axil_soc.f ====
hdl/axil_soc_pkg.sv
hdl/axil_ram.sv
hdl/axil_rtc.sv
hdl/axil_xbar.sv
hdl/axil_soc.sv
testbench/tb_clock.sv
testbench/axil_soc_properties.sv
testbench/axil_soc_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the axil_soc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f axil_soc.f --top-module axil_soc_tb \
	--Mdir obj_dir -o axil_soc_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit $status
fi

./obj_dir/axil_soc_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation finished with status 0"
exit 0
